// ==== build.f ====
+incdir+verification
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/bus_access.sv
hdl/bus_decoder.sv
hdl/bram_latency.sv
hdl/control_regs.sv
hdl/soc_top.sv
verification/tb_soc_top.sv

// ==== hdl/bram_latency.sv ====
`timescale 1ns/100ps

module bram_latency
#(
	parameter int RAM_WORDS   = 1024,
	parameter int RAM_LATENCY = 3
)
(
	input  logic                  clock,
	input  logic                  i_arst_n,
	input  soc_bus_pkg::bus_req_t i_req,
	output soc_bus_pkg::bus_rsp_t o_rsp
);
	import soc_bus_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int CNT_W = $clog2(RAM_LATENCY + 1);

	bus_data_t        mem [RAM_WORDS];
	bus_data_t        rdata_q;
	logic [IDX_W-1:0] word_idx;
	logic [CNT_W-1:0] lat_count;
	logic             busy;
	logic             accept;

	// Word index, wraps for a power of two size
	assign word_idx = i_req.address.mem.offset[IDX_W+1:2];
	assign accept   = i_req.request && !busy;

	// Latency counter from accept to ready
	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			busy <= 1'b0;
			lat_count <= '0;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			lat_count <= CNT_W'(RAM_LATENCY - 1);
		end
		else if (busy)
		begin
			if (lat_count == '0)
				busy <= 1'b0;
			else
				lat_count <= lat_count - 1'b1;
		end
	end

	// Storage and read capture at accept
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			if (i_req.rw)
				mem[word_idx] <= i_req.wdata;
			rdata_q <= mem[word_idx];
		end
	end

	assign o_rsp.ready = busy && (lat_count == '0);
	assign o_rsp.rdata = rdata_q;

endmodule

// ==== hdl/bus_access.sv ====
`timescale 1ns/100ps

module bus_access
(
	input  logic                  clock,
	input  logic                  i_arst_n,

	// Instruction port, read only
	input  soc_bus_pkg::bus_req_t i_port_a,
	output soc_bus_pkg::bus_rsp_t o_port_a,

	// Data port
	input  soc_bus_pkg::bus_req_t i_port_b,
	output soc_bus_pkg::bus_rsp_t o_port_b,

	// DMA port
	input  soc_bus_pkg::bus_req_t i_port_c,
	output soc_bus_pkg::bus_rsp_t o_port_c,

	// Shared bus
	output soc_bus_pkg::bus_req_t o_bus,
	input  soc_bus_pkg::bus_rsp_t i_bus
);
	import soc_bus_pkg::*;

	localparam logic [1:0] GRANT_IDLE = 2'd0;
	localparam logic [1:0] GRANT_A    = 2'd1;
	localparam logic [1:0] GRANT_B    = 2'd2;
	localparam logic [1:0] GRANT_C    = 2'd3;

	logic [1:0] grant;
	bus_req_t   port_a_rd;

	// Instruction port can never write
	always_comb
	begin
		port_a_rd = i_port_a;
		port_a_rd.rw = 1'b0;
	end

	// Grant holds until the target answers, then one idle cycle
	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
			grant <= GRANT_IDLE;
		else
		begin
			case (grant)
				GRANT_IDLE:
				begin
					// Data port first, then DMA, then instruction
					if (i_port_b.request)
						grant <= GRANT_B;
					else if (i_port_c.request)
						grant <= GRANT_C;
					else if (i_port_a.request)
						grant <= GRANT_A;
				end
				default:
				begin
					if (i_bus.ready)
						grant <= GRANT_IDLE;
				end
			endcase
		end
	end

	// Request onto the bus, response back to the owner only
	always_comb
	begin
		o_bus = '0;
		o_port_a = '0;
		o_port_b = '0;
		o_port_c = '0;
		case (grant)
			GRANT_A:
			begin
				o_bus = port_a_rd;
				o_port_a = i_bus;
			end
			GRANT_B:
			begin
				o_bus = i_port_b;
				o_port_b = i_bus;
			end
			GRANT_C:
			begin
				o_bus = i_port_c;
				o_port_c = i_bus;
			end
			default:
			begin
				o_bus = '0;
			end
		endcase
	end

endmodule

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/100ps

module bus_decoder
(
	// Arbitrated bus
	input  soc_bus_pkg::bus_req_t i_bus,
	output soc_bus_pkg::bus_rsp_t o_bus,

	// Target requests
	output soc_bus_pkg::bus_req_t o_ram_req,
	output soc_bus_pkg::bus_req_t o_led_req,
	output soc_bus_pkg::bus_req_t o_timer_req,

	// Target responses
	input  soc_bus_pkg::bus_rsp_t i_ram_rsp,
	input  soc_bus_pkg::bus_rsp_t i_ctrl_rsp
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	region_t region;
	logic    ram_sel;
	logic    led_sel;
	logic    timer_sel;

	// ==============================
	// Region select
	// ==============================

	// Region nibble sits in the same place in both views
	assign region    = i_bus.address.mem.region;
	assign ram_sel   = (region == REGION_RAM);
	assign led_sel   = (region == REGION_LED);
	assign timer_sel = (region == REGION_TIMER);

	// Copies of the bus, request gated per target
	always_comb
	begin
		o_ram_req = i_bus;
		o_ram_req.request = i_bus.request & ram_sel;
		o_led_req = i_bus;
		o_led_req.request = i_bus.request & led_sel;
		o_timer_req = i_bus;
		o_timer_req.request = i_bus.request & timer_sel;
	end

	// ==============================
	// Response mux
	// ==============================

	// Unmapped regions never answer
	always_comb
	begin
		if (ram_sel)
			o_bus = i_ram_rsp;
		else if (led_sel || timer_sel)
			o_bus = i_ctrl_rsp;
		else
			o_bus = '0;
	end

endmodule

// ==== hdl/control_regs.sv ====
`timescale 1ns/100ps

module control_regs
#(
	parameter int TIMER_PRESCALE = 4
)
(
	input  logic                              clock,
	input  logic                              i_arst_n,
	input  soc_bus_pkg::bus_req_t             i_led_req,
	input  soc_bus_pkg::bus_req_t             i_timer_req,
	output soc_bus_pkg::bus_rsp_t             o_rsp,
	output logic [soc_map_pkg::LED_WIDTH-1:0] o_led,
	output logic                              o_irq
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int PSC_W = $clog2(TIMER_PRESCALE + 1);

	logic                 ready_q;
	bus_data_t            rdata_q;
	bus_data_t            read_word;
	logic [LED_WIDTH-1:0] led_q;
	logic                 tmr_enable;
	bus_data_t            tmr_compare;
	bus_data_t            tmr_count;
	logic                 tmr_irq;
	logic [PSC_W-1:0]     psc_count;
	logic                 tick;
	logic                 accept;
	logic                 led_wr;
	logic                 tmr_wr;

	// Shared handshake for both register blocks
	assign accept = !ready_q && (i_led_req.request || i_timer_req.request);
	assign led_wr = accept && i_led_req.request && i_led_req.rw;
	assign tmr_wr = accept && i_timer_req.request && i_timer_req.rw;
	assign tick   = tmr_enable && (psc_count == PSC_W'(TIMER_PRESCALE - 1));

	// ==============================
	// Register state
	// ==============================

	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			ready_q <= 1'b0;
			led_q <= '0;
			tmr_enable <= 1'b0;
			tmr_compare <= '0;
			tmr_count <= '0;
			tmr_irq <= 1'b0;
			psc_count <= '0;
		end
		else
		begin
			ready_q <= accept;
			// Prescaler only runs while enabled
			if (!tmr_enable || tick)
				psc_count <= '0;
			else
				psc_count <= psc_count + 1'b1;
			if (led_wr)
				led_q <= i_led_req.wdata[LED_WIDTH-1:0];
			if (tmr_wr)
			begin
				case (i_timer_req.address.regs.index)
					TMR_CTRL:    tmr_enable <= i_timer_req.wdata[0];
					TMR_COMPARE: tmr_compare <= i_timer_req.wdata;
					TMR_STATUS:  tmr_irq <= 1'b0;
					default:     ;
				endcase
			end
			// A match on the same edge as a clear still raises the interrupt
			if (tick)
			begin
				if (tmr_count == tmr_compare)
				begin
					tmr_count <= '0;
					tmr_irq <= 1'b1;
				end
				else
					tmr_count <= tmr_count + 1'b1;
			end
		end
	end

	// Read mux
	always_comb
	begin
		read_word = '0;
		if (i_led_req.request)
			read_word = bus_data_t'(led_q);
		else
		begin
			case (i_timer_req.address.regs.index)
				TMR_CTRL:    read_word = bus_data_t'(tmr_enable);
				TMR_COMPARE: read_word = tmr_compare;
				TMR_COUNT:   read_word = tmr_count;
				TMR_STATUS:  read_word = bus_data_t'(tmr_irq);
				default:     read_word = '0;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			rdata_q <= read_word;
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;
	assign o_led       = led_q;
	assign o_irq       = tmr_irq;

endmodule

// ==== hdl/soc_bus_pkg.sv ====
package soc_bus_pkg;

	// ==============================
	// Basic bus types
	// ==============================

	typedef logic [31:0] bus_data_t;

	// Top nibble of every byte address
	typedef logic [3:0] region_t;

	// Memory view of an address
	typedef struct packed
	{
		region_t     region;
		logic [27:0] offset;
	} mem_addr_t;

	// Register view of an address
	typedef struct packed
	{
		region_t     region;
		logic [22:0] pad;
		logic [2:0]  index;
		logic [1:0]  byte_sel;
	} reg_addr_t;

	// Same 32 bits, decoded per target
	typedef union packed
	{
		mem_addr_t mem;
		reg_addr_t regs;
	} bus_addr_u;

	// ==============================
	// Request and response
	// ==============================

	// Level request, held until ready
	typedef struct packed
	{
		logic      request;
		logic      rw;
		bus_addr_u address;
		bus_data_t wdata;
	} bus_req_t;

	// One cycle ready pulse, rdata valid with it
	typedef struct packed
	{
		logic      ready;
		bus_data_t rdata;
	} bus_rsp_t;

endpackage

// ==== hdl/soc_map_pkg.sv ====
package soc_map_pkg;

	// ==============================
	// Region codes
	// ==============================

	localparam soc_bus_pkg::region_t REGION_RAM   = 4'h1;
	localparam soc_bus_pkg::region_t REGION_LED   = 4'h4;
	localparam soc_bus_pkg::region_t REGION_TIMER = 4'hA;

	// ==============================
	// Timer registers
	// ==============================

	// Word index inside the timer region
	localparam logic [2:0] TMR_CTRL    = 3'd0;
	localparam logic [2:0] TMR_COMPARE = 3'd1;
	localparam logic [2:0] TMR_COUNT   = 3'd2;
	localparam logic [2:0] TMR_STATUS  = 3'd3;

	// ==============================
	// LED output
	// ==============================

	// Width of the LED bank
	localparam int LED_WIDTH = 10;

endpackage

// ==== hdl/soc_top.sv ====
`timescale 1ns/100ps

module soc_top
#(
	parameter int RAM_WORDS      = 1024,
	parameter int RAM_LATENCY    = 3,
	parameter int TIMER_PRESCALE = 4
)
(
	input  logic                              clock,
	input  logic                              i_arst_n,
	input  soc_bus_pkg::bus_req_t             i_port_a,
	input  soc_bus_pkg::bus_req_t             i_port_b,
	input  soc_bus_pkg::bus_req_t             i_port_c,
	output soc_bus_pkg::bus_rsp_t             o_port_a,
	output soc_bus_pkg::bus_rsp_t             o_port_b,
	output soc_bus_pkg::bus_rsp_t             o_port_c,
	output logic [soc_map_pkg::LED_WIDTH-1:0] o_led,
	output logic                              o_irq
);
	import soc_bus_pkg::*;

	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	bus_req_t ram_req;
	bus_req_t led_req;
	bus_req_t timer_req;
	bus_rsp_t ram_rsp;
	bus_rsp_t ctrl_rsp;

	// ==============================
	// Bus masters side
	// ==============================

	bus_access u_bus_access
	(
		.clock    (clock),
		.i_arst_n (i_arst_n),
		.i_port_a (i_port_a),
		.o_port_a (o_port_a),
		.i_port_b (i_port_b),
		.o_port_b (o_port_b),
		.i_port_c (i_port_c),
		.o_port_c (o_port_c),
		.o_bus    (bus_req),
		.i_bus    (bus_rsp)
	);

	bus_decoder u_bus_decoder
	(
		.i_bus       (bus_req),
		.o_bus       (bus_rsp),
		.o_ram_req   (ram_req),
		.o_led_req   (led_req),
		.o_timer_req (timer_req),
		.i_ram_rsp   (ram_rsp),
		.i_ctrl_rsp  (ctrl_rsp)
	);

	// ==============================
	// Targets
	// ==============================

	bram_latency #(
		.RAM_WORDS   (RAM_WORDS),
		.RAM_LATENCY (RAM_LATENCY)
	) u_ram (
		.clock    (clock),
		.i_arst_n (i_arst_n),
		.i_req    (ram_req),
		.o_rsp    (ram_rsp)
	);

	control_regs #(
		.TIMER_PRESCALE (TIMER_PRESCALE)
	) u_ctrl (
		.clock       (clock),
		.i_arst_n    (i_arst_n),
		.i_led_req   (led_req),
		.i_timer_req (timer_req),
		.o_rsp       (ctrl_rsp),
		.o_led       (o_led),
		.o_irq       (o_irq)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_soc_top -f build.f &&
./obj_dir/Vtb_soc_top | tee /dev/stderr | grep -q "Simulation passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// ==== verification/tb_soc_tasks.svh ====
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

// ==============================
// Bus access
// ==============================

// Request held until the port sees ready, then dropped one cycle later
task automatic bus_transfer(input int port, input logic rw, input bus_data_t addr,
	input bus_data_t wdata, output bus_data_t rdata, output time t_ready);
	bus_req_t req;
	req.request = 1'b1;
	req.rw = rw;
	req.address = addr;
	req.wdata = wdata;
	port_req[port] = req;
	do
	begin
		@(posedge clock);
		#1;
	end
	while (!port_rsp[port].ready);
	rdata = port_rsp[port].rdata;
	t_ready = $time;
	// Keep the request through the ready cycle
	@(posedge clock);
	#1;
	port_req[port] = '0;
endtask

// ==============================
// Compare tasks
// ==============================

task automatic check_data(input bus_data_t got, input bus_data_t expected, input string what);
	if (got !== expected)
		stop_on_error($sformatf("Fail at %0d ns: %s read %h, expected %h",
			$time, what, got, expected));
endtask

task automatic check_led(input logic [LED_WIDTH-1:0] got, input logic [LED_WIDTH-1:0] expected,
	input string what);
	if (got !== expected)
		stop_on_error($sformatf("Fail at %0d ns: %s is %h, expected %h",
			$time, what, got, expected));
endtask

task automatic check_irq(input logic got, input logic expected, input string what);
	if (got !== expected)
		stop_on_error($sformatf("Fail at %0d ns: %s is %b, expected %b",
			$time, what, got, expected));
endtask

// ==============================
// Random data
// ==============================

// Right shifting Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	if (state[0])
		return (state >> 1) ^ 32'h8020_0003;
	else
		return state >> 1;
endfunction

// One step per bit taken
function automatic bus_data_t random_word();
	bus_data_t word;
	word = '0;
	for (int i = 0; i < 32; i++)
	begin
		word = {word[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return word;
endfunction

`endif

// ==== verification/tb_soc_top.sv ====
`timescale 1ns/100ps

module tb_soc_top;
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int RAM_WORDS      = 1024;
	localparam int RAM_LATENCY    = 3;
	localparam int TIMER_PRESCALE = 4;
	localparam int PORT_A         = 0;
	localparam int PORT_B         = 1;
	localparam int PORT_C         = 2;
	localparam int TIMER_WAIT     = (5 + 1) * TIMER_PRESCALE + 20;
	// Contention, readback and timer accesses outside the table
	localparam int EXTRA_OPS      = 12;

	typedef struct
	{
		int        port;
		logic      rw;
		bus_data_t addr;
		logic      use_lfsr;
		bus_data_t wdata;
		logic      exp_model;
		bus_data_t expected;
	} entry_t;

	logic                 clock;
	logic                 i_arst_n;
	bus_req_t             port_req [3];
	bus_rsp_t             port_rsp [3];
	logic [LED_WIDTH-1:0] led;
	logic                 irq;
	entry_t               stim [$];
	bit                   table_ready = 1'b0;
	logic [31:0]          lfsr_state = 32'h7d93;
	bus_data_t            ram_model [int];
	logic [LED_WIDTH-1:0] led_model = '0;

	`include "tb_soc_tasks.svh"

	soc_top #(
		.RAM_WORDS      (RAM_WORDS),
		.RAM_LATENCY    (RAM_LATENCY),
		.TIMER_PRESCALE (TIMER_PRESCALE)
	) uut (
		.clock    (clock),
		.i_arst_n (i_arst_n),
		.i_port_a (port_req[0]),
		.i_port_b (port_req[1]),
		.i_port_c (port_req[2]),
		.o_port_a (port_rsp[0]),
		.o_port_b (port_rsp[1]),
		.o_port_c (port_rsp[2]),
		.o_led    (led),
		.o_irq    (irq)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	// ==============================
	// Addresses and reference model
	// ==============================

	function automatic bus_data_t ram_addr(input int word);
		bus_addr_u a;
		a = '0;
		a.mem.region = REGION_RAM;
		a.mem.offset = 28'(word * 4);
		return a;
	endfunction

	function automatic bus_data_t reg_addr(input region_t region, input logic [2:0] index);
		bus_addr_u a;
		a = '0;
		a.regs.region = region;
		a.regs.index = index;
		return a;
	endfunction

	function automatic void model_write(input int port, input bus_data_t addr,
		input bus_data_t data);
		bus_addr_u a;
		a = addr;
		// Instruction port never writes
		if (port == PORT_A)
			return;
		if (a.mem.region == REGION_RAM)
			ram_model[int'(a.mem.offset[27:2]) % RAM_WORDS] = data;
		else if (a.mem.region == REGION_LED)
			led_model = data[LED_WIDTH-1:0];
	endfunction

	function automatic bus_data_t model_read(input bus_data_t addr);
		bus_addr_u a;
		a = addr;
		if (a.mem.region == REGION_RAM)
			return ram_model[int'(a.mem.offset[27:2]) % RAM_WORDS];
		else if (a.mem.region == REGION_LED)
			return bus_data_t'(led_model);
		return '0;
	endfunction

	// ==============================
	// Stimulus table
	// ==============================

	task automatic add_write(input int port, input bus_data_t addr, input logic use_lfsr,
		input bus_data_t wdata);
		entry_t e;
		e = '{port, 1'b1, addr, use_lfsr, wdata, 1'b0, '0};
		stim.push_back(e);
	endtask

	task automatic add_read(input int port, input bus_data_t addr, input logic exp_model,
		input bus_data_t expected);
		entry_t e;
		e = '{port, 1'b0, addr, 1'b0, '0, exp_model, expected};
		stim.push_back(e);
	endtask

	task automatic build_table();
		// Timer state right after reset
		add_read(PORT_B, reg_addr(REGION_TIMER, TMR_CTRL), 1'b0, 32'h0);
		add_read(PORT_B, reg_addr(REGION_TIMER, TMR_COMPARE), 1'b0, 32'h0);
		add_read(PORT_B, reg_addr(REGION_TIMER, TMR_COUNT), 1'b0, 32'h0);
		// RAM round trip on the data port
		add_write(PORT_B, ram_addr(0), 1'b1, '0);
		add_write(PORT_B, ram_addr(1), 1'b1, '0);
		add_write(PORT_B, ram_addr(4), 1'b1, '0);
		add_write(PORT_B, ram_addr(RAM_WORDS - 1), 1'b1, '0);
		add_read(PORT_B, ram_addr(0), 1'b1, '0);
		add_read(PORT_B, ram_addr(1), 1'b1, '0);
		add_read(PORT_B, ram_addr(4), 1'b1, '0);
		add_read(PORT_B, ram_addr(RAM_WORDS - 1), 1'b1, '0);
		// Wraps onto word 0
		add_read(PORT_B, ram_addr(RAM_WORDS), 1'b1, '0);
		// DMA port read back
		add_read(PORT_C, ram_addr(4), 1'b1, '0);
		// Instruction port reads, and a write that must be ignored
		add_read(PORT_A, ram_addr(0), 1'b1, '0);
		add_read(PORT_A, ram_addr(1), 1'b1, '0);
		add_read(PORT_A, ram_addr(4), 1'b1, '0);
		add_write(PORT_A, ram_addr(1), 1'b0, 32'hdead_beef);
		add_read(PORT_B, ram_addr(1), 1'b1, '0);
		// LED register
		add_write(PORT_B, reg_addr(REGION_LED, 3'd0), 1'b1, '0);
		add_read(PORT_B, reg_addr(REGION_LED, 3'd0), 1'b1, '0);
	endtask

	// ==============================
	// Clock, watchdog, main sequence
	// ==============================

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial
	begin
		int limit;
		wait (table_ready);
		limit = (stim.size() + EXTRA_OPS) * (RAM_LATENCY + 10) + TIMER_WAIT + 5;
		repeat (limit) @(posedge clock);
		$display("Watchdog expired: a bus access never completed");
		$display("Simulation failed");
		$fatal(1, "watchdog timeout");
	end

	initial
	begin
		entry_t    ent;
		bus_data_t wdata;
		bus_data_t rdata;
		bus_data_t expected;
		bus_data_t data_b;
		bus_data_t data_c;
		bus_data_t rd_a;
		time       t_a;
		time       t_b;
		time       t_c;
		int        cycles;
		i_arst_n = 1'b0;
		port_req[0] = '0;
		port_req[1] = '0;
		port_req[2] = '0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		i_arst_n = 1'b1;
		check_led(led, '0, "LED output after reset");
		check_irq(irq, 1'b0, "interrupt after reset");

		foreach (stim[i])
		begin
			ent = stim[i];
			wdata = ent.use_lfsr ? random_word() : ent.wdata;
			bus_transfer(ent.port, ent.rw, ent.addr, wdata, rdata, t_a);
			if (ent.rw)
			begin
				model_write(ent.port, ent.addr, wdata);
				if (ent.addr[31:28] == REGION_LED)
					check_led(led, led_model, "LED output after write");
			end
			else
			begin
				expected = ent.exp_model ? model_read(ent.addr) : ent.expected;
				check_data(rdata, expected, $sformatf("table entry %0d", i));
			end
		end

		// All three ports raised in the same cycle
		data_b = random_word();
		data_c = random_word();
		fork
			bus_transfer(PORT_B, 1'b1, ram_addr(64), data_b, rdata, t_b);
			bus_transfer(PORT_C, 1'b1, ram_addr(65), data_c, rdata, t_c);
			bus_transfer(PORT_A, 1'b0, ram_addr(0), '0, rd_a, t_a);
		join
		if (!(t_b < t_c && t_c < t_a))
			stop_on_error($sformatf("Fail at %0d ns: ready order B %0d, C %0d, A %0d",
				$time, t_b, t_c, t_a));
		check_data(rd_a, model_read(ram_addr(0)), "port A under contention");
		model_write(PORT_B, ram_addr(64), data_b);
		model_write(PORT_C, ram_addr(65), data_c);
		bus_transfer(PORT_B, 1'b0, ram_addr(65), '0, rdata, t_b);
		check_data(rdata, model_read(ram_addr(65)), "word written by port C");

		// Timer with compare 5
		bus_transfer(PORT_B, 1'b1, reg_addr(REGION_TIMER, TMR_COMPARE), 32'd5, rdata, t_b);
		bus_transfer(PORT_B, 1'b1, reg_addr(REGION_TIMER, TMR_CTRL), 32'd1, rdata, t_b);
		cycles = 0;
		while (!irq && cycles < TIMER_WAIT)
		begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!irq)
			stop_on_error("Timer interrupt did not rise within the allowed time");
		bus_transfer(PORT_B, 1'b0, reg_addr(REGION_TIMER, TMR_COUNT), '0, rdata, t_b);
		if (rdata > 5)
			stop_on_error($sformatf("Fail at %0d ns: timer count %0d above compare 5",
				$time, rdata));
		bus_transfer(PORT_B, 1'b0, reg_addr(REGION_TIMER, TMR_STATUS), '0, rdata, t_b);
		check_irq(rdata[0], 1'b1, "status bit with interrupt set");
		// Stop the timer so the interrupt cannot return
		bus_transfer(PORT_B, 1'b1, reg_addr(REGION_TIMER, TMR_CTRL), 32'd0, rdata, t_b);
		bus_transfer(PORT_B, 1'b1, reg_addr(REGION_TIMER, TMR_STATUS), 32'd1, rdata, t_b);
		check_irq(irq, 1'b0, "interrupt after status write");
		bus_transfer(PORT_B, 1'b0, reg_addr(REGION_TIMER, TMR_STATUS), '0, rdata, t_b);
		check_irq(rdata[0], 1'b0, "status bit after clear");

		$display("Simulation passed");
		$finish;
	end

endmodule
